//--- logic/pad_params.svh
/*
  Pad subsystem constants
  Pad count and select width, register port widths,
  register word addresses, reset values, input synchronizer depth
*/
`ifndef PAD_PARAMS_SVH
`define PAD_PARAMS_SVH

`define PAD_N             16
`define PAD_SEL_W         2
`define PAD_REG_ADDR_W    4
`define PAD_DATA_W        32

`define PAD_ADDR_MUX      4'd0
`define PAD_ADDR_GPIO_OUT 4'd1
`define PAD_ADDR_GPIO_DIR 4'd2
`define PAD_ADDR_GPIO_IN  4'd3

`define PAD_MUX_RST       32'h0000_0000 // All pads on GPIO
`define PAD_GPIO_OUT_RST  16'h0000
`define PAD_GPIO_DIR_RST  16'h0000      // All pads input

`define PAD_SYNC_STAGES   2

`endif

//--- logic/pad_pkg.sv
/*
  Pad subsystem types
  Vector typedefs, pad select enum,
  register request and peripheral signal bundles
*/
`include "pad_params.svh"

package pad_pkg;

  typedef logic [`PAD_N-1:0]              pad_vec_t;
  typedef logic [`PAD_N*`PAD_SEL_W-1:0]   pad_mux_t;   // Pad p in bits 2p+1:2p
  typedef logic [`PAD_REG_ADDR_W-1:0]     reg_addr_t;
  typedef logic [`PAD_DATA_W-1:0]         reg_data_t;

  typedef enum logic [`PAD_SEL_W-1:0] {
    PAD_GPIO = 2'd0,
    PAD_ALT1 = 2'd1,
    PAD_ALT2 = 2'd2,
    PAD_OFF  = 2'd3
  } pad_sel_e;

  typedef struct packed {
    logic      req;
    logic      we;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  // Signals from the peripherals towards the pads
  typedef struct packed {
    logic       uart_tx;
    logic       spi_sck;
    logic       spi_csn;
    logic [3:0] spi_sdo;
    logic [3:0] spi_oe;
    logic [1:0] i2c_scl_out;
    logic [1:0] i2c_scl_oe;
    logic [1:0] i2c_sda_out;
    logic [1:0] i2c_sda_oe;
  } periph_out_t;

  typedef struct packed {
    logic       uart_rx;
    logic [3:0] spi_sdi;
    logic [1:0] i2c_scl_in;
    logic [1:0] i2c_sda_in;
  } periph_in_t;

endpackage

//--- logic/padctrl_regs.sv
/*
  Pad control register block
  MUX, GPIO_OUT and GPIO_DIR registers written over a strobe port,
  registered read back of all four words including GPIO_IN
*/
`timescale 1ns/100ps
`include "pad_params.svh"

module padctrl_regs (
  input  logic               ref_clk_i,
  input  logic               arst_n_i,

  input  pad_pkg::reg_req_t  reg_req_i,
  input  pad_pkg::pad_vec_t  gpio_in_i,
  output pad_pkg::reg_data_t reg_rdata_o,
  output logic               reg_rvalid_o,

  output pad_pkg::pad_mux_t  pad_sel_o,
  output pad_pkg::pad_vec_t  gpio_out_o,
  output pad_pkg::pad_vec_t  gpio_dir_o
);

  import pad_pkg::*;

  pad_mux_t  pad_sel_q;
  pad_vec_t  gpio_out_q;
  pad_vec_t  gpio_dir_q;

  reg_data_t rdata_d;
  reg_data_t rdata_q;
  logic      rvalid_q;

  logic      wr_req;
  logic      rd_req;
  logic      hit_mux;
  logic      hit_out;
  logic      hit_dir;
  logic      hit_in;
  logic      wr_ignored;

  assign wr_req = reg_req_i.req & reg_req_i.we;
  assign rd_req = reg_req_i.req & ~reg_req_i.we;

  // Word address decode
  assign hit_mux = (reg_req_i.addr == `PAD_ADDR_MUX);
  assign hit_out = (reg_req_i.addr == `PAD_ADDR_GPIO_OUT);
  assign hit_dir = (reg_req_i.addr == `PAD_ADDR_GPIO_DIR);
  assign hit_in  = (reg_req_i.addr == `PAD_ADDR_GPIO_IN);

  // GPIO_IN and unmapped words take no write
  assign wr_ignored = wr_req & ~(hit_mux | hit_out | hit_dir);

  always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pad_sel_q  <= `PAD_MUX_RST;
      gpio_out_q <= `PAD_GPIO_OUT_RST;
      gpio_dir_q <= `PAD_GPIO_DIR_RST;
    end else if (wr_req) begin
      if (hit_mux) pad_sel_q  <= reg_req_i.wdata[$bits(pad_mux_t)-1:0];
      if (hit_out) gpio_out_q <= reg_req_i.wdata[`PAD_N-1:0];
      if (hit_dir) gpio_dir_q <= reg_req_i.wdata[`PAD_N-1:0];
    end
  end

  always_comb begin
    rdata_d = '0;                                   // Unmapped words read zero
    if (hit_mux) rdata_d = reg_data_t'(pad_sel_q);
    if (hit_out) rdata_d = reg_data_t'(gpio_out_q);
    if (hit_dir) rdata_d = reg_data_t'(gpio_dir_q);
    if (hit_in)  rdata_d = reg_data_t'(gpio_in_i);  // Already synchronized
  end

  always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_req;
    end
  end

  always_ff @(posedge ref_clk_i) begin
    if (rd_req) rdata_q <= rdata_d;
  end

  assign reg_rdata_o  = rdata_q;
  assign reg_rvalid_o = rvalid_q;

  assign pad_sel_o  = pad_sel_q;
  assign gpio_out_o = gpio_out_q;
  assign gpio_dir_o = gpio_dir_q;

  // Read response is a single pulse tied to its request
  a_rvalid_follows_read: assert property (
    @(posedge ref_clk_i) disable iff (!arst_n_i)
    rd_req |=> reg_rvalid_o
  );

  a_rvalid_only_after_read: assert property (
    @(posedge ref_clk_i) disable iff (!arst_n_i)
    reg_rvalid_o |-> $past(rd_req)
  );

  a_ignored_write_keeps_state: assert property (
    @(posedge ref_clk_i) disable iff (!arst_n_i)
    wr_ignored |=> $stable(pad_sel_q) && $stable(gpio_out_q) && $stable(gpio_dir_q)
  );

endmodule

//--- logic/pad_mux.sv
/*
  Pad mux
  Per-pad choice of GPIO, alternate function or off on the output side,
  synchronizer chain and peripheral input selection on the input side
*/
`timescale 1ns/100ps
`include "pad_params.svh"

module pad_mux (
  input  logic                 ref_clk_i,
  input  logic                 arst_n_i,

  input  pad_pkg::pad_mux_t    pad_sel_i,
  input  pad_pkg::pad_vec_t    gpio_out_i,
  input  pad_pkg::pad_vec_t    gpio_dir_i,
  output pad_pkg::pad_vec_t    gpio_in_o,

  input  pad_pkg::periph_out_t periph_out_i,
  output pad_pkg::periph_in_t  periph_in_o,

  input  pad_pkg::pad_vec_t    pad_in_i,
  output pad_pkg::pad_vec_t    pad_out_o,
  output pad_pkg::pad_vec_t    pad_oe_o
);

  import pad_pkg::*;

  pad_sel_e sel [`PAD_N];
  pad_vec_t alt1_out;
  pad_vec_t alt1_oe;
  pad_vec_t alt2_out;
  pad_vec_t alt2_oe;
  pad_vec_t sync_q [`PAD_SYNC_STAGES];
  pad_vec_t pad_sync;

  for (genvar p = 0; p < `PAD_N; p++) begin : g_sel
    assign sel[p] = pad_sel_e'(pad_sel_i[p*`PAD_SEL_W +: `PAD_SEL_W]);

    a_off_no_drive: assert property (
      @(posedge ref_clk_i) disable iff (!arst_n_i)
      (sel[p] == PAD_OFF) |-> !pad_oe_o[p]
    );
  end

  // Alternate function table with all other entries at 0
  always_comb begin
    alt1_out = '0;
    alt1_oe  = '0;
    alt2_out = '0;
    alt2_oe  = '0;

    alt1_out[0]   = periph_out_i.uart_tx;
    alt1_oe[0]    = 1'b1;
    alt1_out[2]   = periph_out_i.spi_sck;
    alt1_oe[2]    = 1'b1;
    alt1_out[3]   = periph_out_i.spi_csn;
    alt1_oe[3]    = 1'b1;
    alt1_out[7:4] = periph_out_i.spi_sdo;   // Quad lanes 0 to 3
    alt1_oe[7:4]  = periph_out_i.spi_oe;
    alt1_out[8]   = periph_out_i.i2c_scl_out[0];
    alt1_oe[8]    = periph_out_i.i2c_scl_oe[0];
    alt1_out[9]   = periph_out_i.i2c_sda_out[0];
    alt1_oe[9]    = periph_out_i.i2c_sda_oe[0];
    alt1_out[10]  = periph_out_i.i2c_scl_out[1];
    alt1_oe[10]   = periph_out_i.i2c_scl_oe[1];
    alt1_out[11]  = periph_out_i.i2c_sda_out[1];
    alt1_oe[11]   = periph_out_i.i2c_sda_oe[1];

    alt2_out[12]  = periph_out_i.uart_tx;   // Relocated UART
    alt2_oe[12]   = 1'b1;
  end

  always_comb begin
    for (int p = 0; p < `PAD_N; p++) begin
      case (sel[p])
        PAD_GPIO: begin
          pad_out_o[p] = gpio_out_i[p];
          pad_oe_o[p]  = gpio_dir_i[p];
        end
        PAD_ALT1: begin
          pad_out_o[p] = alt1_out[p];
          pad_oe_o[p]  = alt1_oe[p];
        end
        PAD_ALT2: begin
          pad_out_o[p] = alt2_out[p];
          pad_oe_o[p]  = alt2_oe[p];
        end
        default: begin
          pad_out_o[p] = 1'b0;
          pad_oe_o[p]  = 1'b0;
        end
      endcase
    end
  end

  // Input synchronizer into the ref_clk domain
  always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < `PAD_SYNC_STAGES; s++) sync_q[s] <= '0;
    end else begin
      sync_q[0] <= pad_in_i;
      for (int s = 1; s < `PAD_SYNC_STAGES; s++) sync_q[s] <= sync_q[s-1];
    end
  end

  assign pad_sync  = sync_q[`PAD_SYNC_STAGES-1];
  assign gpio_in_o = pad_sync;

  // Unselected inputs sit at their bus idle level
  always_comb begin
    if (sel[1] == PAD_ALT1) periph_in_o.uart_rx = pad_sync[1];
    else if (sel[13] == PAD_ALT2) periph_in_o.uart_rx = pad_sync[13];
    else periph_in_o.uart_rx = 1'b1;

    for (int i = 0; i < 4; i++) begin
      periph_in_o.spi_sdi[i] = (sel[4+i] == PAD_ALT1) ? pad_sync[4+i] : 1'b0;
    end

    for (int b = 0; b < 2; b++) begin
      periph_in_o.i2c_scl_in[b] = (sel[8+2*b] == PAD_ALT1) ? pad_sync[8+2*b] : 1'b1;
      periph_in_o.i2c_sda_in[b] = (sel[9+2*b] == PAD_ALT1) ? pad_sync[9+2*b] : 1'b1;
    end
  end

endmodule

//--- logic/pad_subsystem.sv
/*
  Pad subsystem top level
  Register block and pad mux between the peripheral bundle
  and the sixteen chip pads
*/
`timescale 1ns/100ps

module pad_subsystem (
  input  logic                 ref_clk_i,
  input  logic                 arst_n_i,

  // Register port
  input  pad_pkg::reg_req_t    reg_req_i,
  output pad_pkg::reg_data_t   reg_rdata_o,
  output logic                 reg_rvalid_o,

  // SoC peripheral side
  input  pad_pkg::periph_out_t periph_out_i,
  output pad_pkg::periph_in_t  periph_in_o,

  // Pad frame
  input  pad_pkg::pad_vec_t    pad_in_i,
  output pad_pkg::pad_vec_t    pad_out_o,
  output pad_pkg::pad_vec_t    pad_oe_o
);

  import pad_pkg::*;

  pad_mux_t s_pad_sel;
  pad_vec_t s_gpio_out;
  pad_vec_t s_gpio_dir;
  pad_vec_t s_gpio_in;   // From the synchronizers

  padctrl_regs i_padctrl_regs (
    .ref_clk_i    ( ref_clk_i    ),
    .arst_n_i     ( arst_n_i     ),

    .reg_req_i    ( reg_req_i    ),
    .gpio_in_i    ( s_gpio_in    ),
    .reg_rdata_o  ( reg_rdata_o  ),
    .reg_rvalid_o ( reg_rvalid_o ),

    .pad_sel_o    ( s_pad_sel    ),
    .gpio_out_o   ( s_gpio_out   ),
    .gpio_dir_o   ( s_gpio_dir   )
  );

  pad_mux i_pad_mux (
    .ref_clk_i    ( ref_clk_i    ),
    .arst_n_i     ( arst_n_i     ),

    .pad_sel_i    ( s_pad_sel    ),
    .gpio_out_i   ( s_gpio_out   ),
    .gpio_dir_i   ( s_gpio_dir   ),
    .gpio_in_o    ( s_gpio_in    ),

    .periph_out_i ( periph_out_i ),
    .periph_in_o  ( periph_in_o  ),

    .pad_in_i     ( pad_in_i     ),
    .pad_out_o    ( pad_out_o    ),
    .pad_oe_o     ( pad_oe_o     )
  );

endmodule

//--- tb/tb_pad_subsystem.sv
/*
  Testbench for the pad subsystem
  Clock and reset, register and pad stimulus, reference model,
  concurrent checks on pads, peripheral inputs and read data
*/
`timescale 1ns/100ps
`include "pad_params.svh"

module tb_pad_subsystem;

  import pad_pkg::*;

  localparam int CLK_HALF   = 5;
  localparam int RD_TIMEOUT = 20;   // Cycles to wait for a read response

  logic        ref_clk;
  logic        arst_n;
  reg_req_t    reg_req;
  reg_data_t   reg_rdata;
  logic        reg_rvalid;
  periph_out_t periph_out;
  periph_in_t  periph_in;
  pad_vec_t    pad_in;
  pad_vec_t    pad_out;
  pad_vec_t    pad_oe;

  int          errors;
  int          tests;
  integer      seed;

  // Reference model state
  pad_mux_t    m_sel;
  pad_vec_t    m_out;
  pad_vec_t    m_dir;
  reg_data_t   m_rdata;
  logic        m_rvalid;
  pad_vec_t    exp_out;
  pad_vec_t    exp_oe;

  pad_subsystem i_pad_subsystem (
    .ref_clk_i    ( ref_clk    ),
    .arst_n_i     ( arst_n     ),
    .reg_req_i    ( reg_req    ),
    .reg_rdata_o  ( reg_rdata  ),
    .reg_rvalid_o ( reg_rvalid ),
    .periph_out_i ( periph_out ),
    .periph_in_o  ( periph_in  ),
    .pad_in_i     ( pad_in     ),
    .pad_out_o    ( pad_out    ),
    .pad_oe_o     ( pad_oe     )
  );

  initial begin
    ref_clk = 1'b0;
    forever #CLK_HALF ref_clk = ~ref_clk;
  end

  function automatic pad_sel_e sel_of(pad_mux_t s, int p);
    logic [31:0] sh;
    sh = s >> (2 * p);
    return pad_sel_e'(sh[1:0]);
  endfunction

  // Returns {oe, out} for one pad
  function automatic logic [1:0] exp_pad(int p, pad_sel_e s, logic g_out, logic g_dir,
                                         periph_out_t po);
    logic [1:0] r;
    r = 2'b00;
    if (s == PAD_GPIO) begin
      r = {g_dir, g_out};
    end else if (s == PAD_ALT1) begin
      case (p)
        0:       r = {1'b1, po.uart_tx};
        2:       r = {1'b1, po.spi_sck};
        3:       r = {1'b1, po.spi_csn};
        4:       r = {po.spi_oe[0], po.spi_sdo[0]};
        5:       r = {po.spi_oe[1], po.spi_sdo[1]};
        6:       r = {po.spi_oe[2], po.spi_sdo[2]};
        7:       r = {po.spi_oe[3], po.spi_sdo[3]};
        8:       r = {po.i2c_scl_oe[0], po.i2c_scl_out[0]};
        9:       r = {po.i2c_sda_oe[0], po.i2c_sda_out[0]};
        10:      r = {po.i2c_scl_oe[1], po.i2c_scl_out[1]};
        11:      r = {po.i2c_sda_oe[1], po.i2c_sda_out[1]};
        default: r = 2'b00;   // Pad 1 is input only and 12 to 15 have no ALT1
      endcase
    end else if (s == PAD_ALT2 && p == 12) begin
      r = {1'b1, po.uart_tx};
    end
    return r;
  endfunction

  function automatic periph_in_t exp_periph_in(pad_mux_t s, pad_vec_t pads);
    periph_in_t r;
    r.uart_rx = 1'b1;
    if (sel_of(s, 1) == PAD_ALT1) r.uart_rx = pads[1];
    else if (sel_of(s, 13) == PAD_ALT2) r.uart_rx = pads[13];
    r.spi_sdi    = 4'b0000;
    r.i2c_scl_in = 2'b11;
    r.i2c_sda_in = 2'b11;
    for (int i = 0; i < 4; i++) begin
      if (sel_of(s, 4 + i) == PAD_ALT1) r.spi_sdi[i] = pads[4 + i];
    end
    for (int b = 0; b < 2; b++) begin
      if (sel_of(s, 8 + 2 * b) == PAD_ALT1) r.i2c_scl_in[b] = pads[8 + 2 * b];
      if (sel_of(s, 9 + 2 * b) == PAD_ALT1) r.i2c_sda_in[b] = pads[9 + 2 * b];
    end
    return r;
  endfunction

  always_comb begin
    for (int p = 0; p < `PAD_N; p++) begin
      {exp_oe[p], exp_out[p]} = exp_pad(p, sel_of(m_sel, p), m_out[p], m_dir[p], periph_out);
    end
  end

  always @(posedge ref_clk or negedge arst_n) begin
    if (!arst_n) begin
      m_sel   <= '0;
      m_out   <= '0;
      m_dir   <= '0;
      m_rdata <= '0;
    end else if (reg_req.req && reg_req.we) begin
      case (reg_req.addr)
        `PAD_ADDR_MUX:      m_sel <= reg_req.wdata;
        `PAD_ADDR_GPIO_OUT: m_out <= reg_req.wdata[`PAD_N-1:0];
        `PAD_ADDR_GPIO_DIR: m_dir <= reg_req.wdata[`PAD_N-1:0];
        default: ;          // GPIO_IN is read-only
      endcase
    end else if (reg_req.req) begin
      case (reg_req.addr)
        `PAD_ADDR_MUX:      m_rdata <= m_sel;
        `PAD_ADDR_GPIO_OUT: m_rdata <= {16'h0000, m_out};
        `PAD_ADDR_GPIO_DIR: m_rdata <= {16'h0000, m_dir};
        `PAD_ADDR_GPIO_IN:  m_rdata <= {16'h0000, pad_in};   // Held 2+ cycles before reads
        default:            m_rdata <= '0;
      endcase
    end
  end

  // One response pulse in the cycle after each read request
  always @(posedge ref_clk or negedge arst_n) begin
    if (!arst_n) begin
      m_rvalid <= 1'b0;
    end else begin
      m_rvalid <= reg_req.req && !reg_req.we;
    end
  end

  a_pads: assert property (
    @(posedge ref_clk) disable iff (!arst_n)
    (pad_out == exp_out) && (pad_oe == exp_oe)
  ) else begin
    errors++;
    $display("[ERROR] %0t: pad_out %h oe %h, expected out %h oe %h", $time,
             $sampled(pad_out), $sampled(pad_oe), $sampled(exp_out), $sampled(exp_oe));
  end

  a_periph_in: assert property (
    @(posedge ref_clk) disable iff (!arst_n)
    periph_in == exp_periph_in(m_sel, $past(pad_in, 2))
  ) else begin
    errors++;
    $display("[ERROR] %0t: periph_in %h does not match pads two cycles earlier", $time,
             $sampled(periph_in));
  end

  a_rvalid: assert property (
    @(posedge ref_clk) disable iff (!arst_n)
    reg_rvalid == m_rvalid
  ) else begin
    errors++;
    $display("[ERROR] %0t: read valid %b, expected %b", $time,
             $sampled(reg_rvalid), $sampled(m_rvalid));
  end

  a_rdata: assert property (
    @(posedge ref_clk) disable iff (!arst_n)
    reg_rvalid |-> (reg_rdata == m_rdata)
  ) else begin
    errors++;
    $display("[ERROR] %0t: read data %h, expected %h", $time,
             $sampled(reg_rdata), $sampled(m_rdata));
  end

  function automatic reg_data_t next_rand();
    return $random(seed);
  endfunction

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(negedge ref_clk);
    reg_req.req   = 1'b1;
    reg_req.we    = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = data;
    @(negedge ref_clk);
    reg_req.req   = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr);
    int n;
    @(negedge ref_clk);
    reg_req.req   = 1'b1;
    reg_req.we    = 1'b0;
    reg_req.addr  = addr;
    reg_req.wdata = '0;
    @(negedge ref_clk);
    reg_req.req   = 1'b0;
    n = 0;
    while (!reg_rvalid && n < RD_TIMEOUT) begin
      @(negedge ref_clk);
      n++;
    end
    if (!reg_rvalid) begin
      errors++;
      $display("Read of address %0d got no response within %0d cycles", addr, RD_TIMEOUT);
    end
  endtask

  // Three reads on consecutive cycles must give three response pulses
  task automatic read_back_to_back();
    int pulses;
    int n;
    pulses = 0;
    for (int a = 0; a < 3; a++) begin
      @(negedge ref_clk);
      if (reg_rvalid) pulses++;
      reg_req.req  = 1'b1;
      reg_req.we   = 1'b0;
      reg_req.addr = reg_addr_t'(a);
    end
    n = 0;
    while (pulses < 3 && n < RD_TIMEOUT) begin
      @(negedge ref_clk);
      reg_req.req = 1'b0;
      if (reg_rvalid) pulses++;
      n++;
    end
    if (pulses < 3) begin
      errors++;
      $display("Back-to-back reads returned %0d of 3 responses", pulses);
    end
  endtask

  task automatic drive_random_inputs(input int cycles);
    reg_data_t w0;
    reg_data_t w1;
    repeat (cycles) begin
      @(negedge ref_clk);
      w0         = next_rand();
      w1         = next_rand();
      periph_out = w0[$bits(periph_out_t)-1:0];
      pad_in     = w1[`PAD_N-1:0];
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s finished, %0d errors so far", tests, name, errors);
  endtask

  initial begin
    reg_data_t w;
    seed       = 20165;
    errors     = 0;
    tests      = 0;
    arst_n     = 1'b0;
    reg_req    = '0;
    periph_out = '0;
    pad_in     = '0;
    repeat (10) @(posedge ref_clk);
    @(negedge ref_clk);
    arst_n = 1'b1;

    repeat (3) @(negedge ref_clk);
    read_reg(`PAD_ADDR_MUX);
    read_reg(`PAD_ADDR_GPIO_OUT);
    read_reg(`PAD_ADDR_GPIO_DIR);
    write_reg(4'd9, next_rand());   // Unmapped word
    read_reg(4'd9);
    write_reg(`PAD_ADDR_GPIO_IN, next_rand());
    read_reg(`PAD_ADDR_MUX);
    finish_test("reset values");

    for (int i = 0; i < 12; i++) begin
      write_reg(`PAD_ADDR_GPIO_OUT, next_rand());
      write_reg(`PAD_ADDR_GPIO_DIR, next_rand());
      read_reg(`PAD_ADDR_GPIO_OUT);
      read_reg(`PAD_ADDR_GPIO_DIR);
    end
    read_back_to_back();
    finish_test("gpio output");

    write_reg(`PAD_ADDR_MUX, next_rand());   // Mixed selects
    for (int i = 0; i < 10; i++) begin
      @(negedge ref_clk);
      w      = next_rand();
      pad_in = w[`PAD_N-1:0];
      repeat (2) @(negedge ref_clk);
      read_reg(`PAD_ADDR_GPIO_IN);
    end
    finish_test("gpio input");

    write_reg(`PAD_ADDR_MUX, 32'h0055_5555);   // Pads 0 to 11 on ALT1
    drive_random_inputs(30);
    finish_test("alternate functions");

    write_reg(`PAD_ADDR_MUX, 32'h0A00_0000);   // UART on pads 12 and 13
    drive_random_inputs(20);
    write_reg(`PAD_ADDR_MUX, 32'h0A00_0004);   // Pad 1 wins over pad 13
    drive_random_inputs(20);
    write_reg(`PAD_ADDR_GPIO_DIR, 32'h0000_FFFF);
    write_reg(`PAD_ADDR_MUX, 32'h1000_00FF);   // Pads 0 to 3 off, pad 14 on ALT1
    drive_random_inputs(20);
    write_reg(`PAD_ADDR_MUX, 32'hFFFF_FFFF);
    drive_random_inputs(20);
    finish_test("relocation and disable");

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+logic
logic/pad_pkg.sv
logic/padctrl_regs.sv
logic/pad_mux.sv
logic/pad_subsystem.sv
tb/tb_pad_subsystem.sv

//--- Makefile
# Verilator simulation of the pad subsystem

VERILATOR ?= verilator
TOP       ?= tb_pad_subsystem
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= === PASS ===
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
